// File: filelist.f
src/fpu_pkg.sv
src/operand_forward.sv
src/fwd_network.sv
src/issue_decode.sv
src/logic_perm_unit.sv
src/fp_compare_unit.sv
src/fpu_lanes.sv
testbench/tb_fpu_lanes.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_fpu_lanes -f filelist.f
out=$(./obj_dir/Vtb_fpu_lanes)
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: testbench/tb_fpu_lanes.sv
// random testbench for fpu_lanes with a cycle model of both lanes and the forwarding
// outputs checked 2 ns after each rising edge before the next inputs are driven
module tb_fpu_lanes;
  timeunit 1ns;
  timeprecision 1ps;
  import fpu_pkg::*;

  localparam int RAND_CYCLES = 3000;
  localparam int FULL_FROM   = 1000;
  localparam int LAT_TIMEOUT = 10;

  logic                   clk;
  logic                   rst;
  issue_t                 issue0;
  issue_t                 issue1;
  logic [1:0][DATA_W-1:0] ext_bus;
  fpcsr_t                 fpcsr;
  perm_result_t           res0;
  cmp_result_t            res1;

  logic [31:0]  rng_state = 32'h54f2_3027;
  int           errors;
  int           checks;
  // model state for bus history, issued items and results due next cycle
  bus_array_t   prev_bus;
  stage_t       st0;
  stage_t       st1;
  perm_result_t exp0;
  cmp_result_t  exp1;

  fpu_lanes UUT (
    .clk     (clk),
    .rst     (rst),
    .issue0  (issue0),
    .issue1  (issue1),
    .ext_bus (ext_bus),
    .fpcsr   (fpcsr),
    .res0    (res0),
    .res1    (res1)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // singles biased toward zeros, denormals, NaNs and infinities
  function automatic logic [31:0] rand_single();
    logic [31:0] r;
    logic [31:0] m;
    r = next_rand();
    m = next_rand();
    case (r[2:0])
      3'd0: return {r[31], 31'd0};
      3'd1: return {r[31], 8'h00, m[22:1], 1'b1};
      3'd2: return {r[31], 8'hff, 1'b1, m[21:0]};
      3'd3: return {r[31], 8'hff, 1'b0, m[21:1], 1'b1};
      3'd4: return {r[31], 8'hff, 23'd0};
      default: return m;
    endcase
  endfunction

  function automatic fwd_sel_t rand_sel();
    logic [31:0] r;
    fwd_sel_t    s;
    r = next_rand();
    if (r[7:0] < 8'd86) begin
      s.src = src_reg;
    end else if (r[7:0] < 8'd171) begin
      s.src = src_now;
    end else begin
      s.src = src_prev;
    end
    s.idx = r[9:8];
    return s;
  endfunction

  function automatic logic [DATA_W-1:0] fwd_model(input logic [DATA_W-1:0] reg_val,
                                                  input fwd_sel_t sel,
                                                  input bus_array_t now_bus);
    if (sel.src == src_now) return now_bus[sel.idx];
    if (sel.src == src_prev) return prev_bus[sel.idx];
    return reg_val;
  endfunction

  function automatic logic [DATA_W-1:0] perm_model(input logic [OP_W-1:0] op,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
    case (op)
      op_and:    return a & b;
      op_or:     return a | b;
      op_xor:    return a ^ b;
      op_andn:   return a & ~b;
      op_swap:   return {b[31:0], b[63:32]};
      op_dup:    return {b[31:0], b[31:0]};
      op_ins_lo: return {b[63:32], a[31:0]};
      default:   return {a[63:32], b[31:0]};
    endcase
  endfunction

  // unsigned key that orders non-NaN singles with both zeros on one key
  function automatic logic [31:0] order_key(input logic [31:0] x, input logic daz);
    logic [31:0] v;
    v = x;
    if (daz && v[30:23] == 8'h00) v[22:0] = 23'd0;
    if (v[30:0] == 31'd0) v = 32'd0;
    if (v[31]) return ~v;
    return v | 32'h8000_0000;
  endfunction

  function automatic cmp_result_t cmp_model(input stage_t s, input fpcsr_t csr);
    logic [31:0] a;
    logic [31:0] b;
    logic        a_nan;
    logic        b_nan;
    logic        a_den;
    logic        b_den;
    logic [31:0] ka;
    logic [31:0] kb;
    cmp_result_t r;
    a = s.a[31:0];
    b = s.b[31:0];
    a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    a_den = (a[30:23] == 8'h00) && (a[22:0] != 23'd0);
    b_den = (b[30:23] == 8'h00) && (b[22:0] != 23'd0);
    ka = order_key(a, csr.daz);
    kb = order_key(b, csr.daz);
    r.valid = s.valid;
    r.tag = s.tag;
    r.data = '0;
    if (a_nan || b_nan) r.data[3] = 1'b1;
    else if (ka < kb) r.data[0] = 1'b1;
    else if (ka == kb) r.data[1] = 1'b1;
    else r.data[2] = 1'b1;
    r.flags.invalid = (a_nan && !a[22]) || (b_nan && !b[22]) ||
                      (s.op == cmp_signal && (a_nan || b_nan));
    r.flags.denorm = (a_den || b_den) && !csr.daz;
    r.excpt = s.valid && ((r.flags.invalid && csr.trap_en.invalid) ||
                          (r.flags.denorm && csr.trap_en.denorm));
    return r;
  endfunction

  task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic advance();
    @(posedge clk);
    #2;
    check_val("res0.valid", 64'(res0.valid), 64'(exp0.valid));
    check_val("res1.valid", 64'(res1.valid), 64'(exp1.valid));
    check_val("res1.excpt", 64'(res1.excpt), 64'(exp1.excpt));
    if (exp0.valid) begin
      check_val("res0.tag", 64'(res0.tag), 64'(exp0.tag));
      check_val("res0.data", res0.data, exp0.data);
    end
    if (exp1.valid) begin
      check_val("res1.tag", 64'(res1.tag), 64'(exp1.tag));
      check_val("res1.data", res1.data, exp1.data);
      check_val("res1.flags", 64'(res1.flags), 64'(exp1.flags));
    end
  endtask

  // results of last cycle's issues, then forwarding of this cycle's issues
  task automatic model_update();
    bus_array_t now_bus;
    now_bus[0] = res0.data;
    now_bus[1] = res1.data;
    now_bus[2] = ext_bus[0];
    now_bus[3] = ext_bus[1];
    exp0.valid = st0.valid && !rst;
    exp0.tag = st0.tag;
    exp0.data = perm_model(st0.op, st0.a, st0.b);
    exp1 = cmp_model(st1, fpcsr);
    if (rst) begin
      exp1.valid = 1'b0;
      exp1.excpt = 1'b0;
    end
    st0.valid = issue0.valid && !rst;
    st0.tag = issue0.tag;
    st0.op = issue0.op;
    st0.a = fwd_model(issue0.a_reg, issue0.a_sel, now_bus);
    st0.b = fwd_model(issue0.b_reg, issue0.b_sel, now_bus);
    st1.valid = issue1.valid && !rst;
    st1.tag = issue1.tag;
    st1.op = issue1.op;
    st1.a = fwd_model(issue1.a_reg, issue1.a_sel, now_bus);
    st1.b = fwd_model(issue1.b_reg, issue1.b_sel, now_bus);
    prev_bus = now_bus;
  endtask

  task automatic drive_idle();
    issue0 = '0;
    issue1 = '0;
  endtask

  task automatic drive_random(input int cyc);
    logic [31:0] r;
    logic [31:0] a_lo;
    r = next_rand();
    a_lo = rand_single();
    issue0.valid = (cyc >= FULL_FROM) ? 1'b1 : (r[0] | r[1]);
    issue0.tag = r[7:2];
    issue0.op = r[10:8];
    issue0.a_reg = {next_rand(), rand_single()};
    issue0.b_reg = {next_rand(), rand_single()};
    issue0.a_sel = rand_sel();
    issue0.b_sel = rand_sel();
    issue1.valid = (cyc >= FULL_FROM) ? 1'b1 : (r[11] | r[12]);
    issue1.tag = r[18:13];
    issue1.op = {2'b00, r[19]};
    issue1.a_reg = {next_rand(), a_lo};
    // equal operands now and then
    issue1.b_reg = {next_rand(), (r[22:20] == 3'd0) ? a_lo : rand_single()};
    issue1.a_sel = rand_sel();
    issue1.b_sel = rand_sel();
    ext_bus[0] = {next_rand(), rand_single()};
    ext_bus[1] = {next_rand(), rand_single()};
    fpcsr = fpcsr_t'(r[25:23]);
  endtask

  initial begin
    int wait_cycles;
    errors = 0;
    checks = 0;
    rst = 1'b1;
    drive_idle();
    ext_bus = '0;
    fpcsr = '0;
    model_update();
    advance();
    model_update();
    advance();
    rst = 1'b0;
    model_update();
    advance();
    model_update();
    advance();

    // first issue is a swap on lane 0 and -0 against +0 on lane 1
    issue0.valid = 1'b1;
    issue0.tag = 6'h15;
    issue0.op = op_swap;
    issue0.a_reg = 64'h0123_4567_89ab_cdef;
    issue0.b_reg = 64'hfedc_ba98_7654_3210;
    issue1.valid = 1'b1;
    issue1.tag = 6'h2a;
    issue1.op = cmp_signal;
    issue1.a_reg = 64'h0000_0000_8000_0000;
    issue1.b_reg = 64'h0;
    model_update();
    wait_cycles = 0;
    do begin
      advance();
      drive_idle();
      model_update();
      wait_cycles++;
    end while (!res0.valid && wait_cycles < LAT_TIMEOUT);
    if (!res0.valid) begin
      errors++;
      $display("first lane 0 result never became valid within %0d cycles", LAT_TIMEOUT);
    end else begin
      check_val("first result latency", 64'(wait_cycles), 64'd2);
    end

    for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
      advance();
      drive_random(cyc);
      model_update();
    end
    // drain the two items still in flight
    repeat (3) begin
      advance();
      drive_idle();
      model_update();
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src/fpu_lanes.sv
// two-lane FP execution unit, fixed 2-cycle latency, no back-pressure
// a valid issue is accepted every cycle on each lane
module fpu_lanes (
  input  logic                                clk,
  input  logic                                rst,
  input  fpu_pkg::issue_t                     issue0,
  input  fpu_pkg::issue_t                     issue1,
  input  logic [1:0][fpu_pkg::DATA_W-1:0]     ext_bus,
  input  fpu_pkg::fpcsr_t                     fpcsr,
  output fpu_pkg::perm_result_t               res0,
  output fpu_pkg::cmp_result_t                res1
);
  import fpu_pkg::*;

  bus_array_t        buses;
  logic [DATA_W-1:0] a0;
  logic [DATA_W-1:0] b0;
  logic [DATA_W-1:0] a1;
  logic [DATA_W-1:0] b1;
  stage_t            stage0;
  stage_t            stage1;

  // own results first, then the external buses
  assign buses[0] = res0.data;
  assign buses[1] = res1.data;
  assign buses[2] = ext_bus[0];
  assign buses[3] = ext_bus[1];

  fwd_network u_fwd (
    .clk    (clk),
    .issue0 (issue0),
    .issue1 (issue1),
    .buses  (buses),
    .a0     (a0),
    .b0     (b0),
    .a1     (a1),
    .b1     (b1)
  );

  issue_decode u_decode (
    .clk    (clk),
    .rst    (rst),
    .issue0 (issue0),
    .issue1 (issue1),
    .a0     (a0),
    .b0     (b0),
    .a1     (a1),
    .b1     (b1),
    .stage0 (stage0),
    .stage1 (stage1)
  );

  logic_perm_unit u_lane0 (
    .clk   (clk),
    .rst   (rst),
    .stage (stage0),
    .res   (res0)
  );

  fp_compare_unit u_lane1 (
    .clk   (clk),
    .rst   (rst),
    .stage (stage1),
    .fpcsr (fpcsr),
    .res   (res1)
  );

endmodule

// File: src/fp_compare_unit.sv
// lane 1 scalar single compare on the low 32 bits of A and B
// only invalid and denormal-operand flags; excpt uses fpcsr of the compute cycle
module fp_compare_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  fpu_pkg::stage_t      stage,
  input  fpu_pkg::fpcsr_t      fpcsr,
  output fpu_pkg::cmp_result_t res
);
  import fpu_pkg::*;

  logic [SNG_W-1:0] a_s;
  logic [SNG_W-1:0] b_s;
  logic [SNG_W-2:0] a_mag;
  logic [SNG_W-2:0] b_mag;
  logic             a_nan;
  logic             b_nan;
  logic             a_snan;
  logic             b_snan;
  logic             a_den;
  logic             b_den;
  logic             signal_cmp;
  logic             lt;
  logic             eq;
  logic             gt;
  logic             unord;
  fp_flags_t        flags_d;

  function automatic logic is_nan(input logic [SNG_W-1:0] x);
    return (x[SNG_W-2 -: EXP_W] == '1) && (x[MAN_W-1:0] != '0);
  endfunction

  function automatic logic is_den(input logic [SNG_W-1:0] x);
    return (x[SNG_W-2 -: EXP_W] == '0) && (x[MAN_W-1:0] != '0);
  endfunction

  assign a_s = stage.a[SNG_W-1:0];
  assign b_s = stage.b[SNG_W-1:0];

  assign a_nan  = is_nan(a_s);
  assign b_nan  = is_nan(b_s);
  // signaling NaN has the top mantissa bit clear
  assign a_snan = a_nan & ~a_s[MAN_W-1];
  assign b_snan = b_nan & ~b_s[MAN_W-1];
  assign a_den  = is_den(a_s);
  assign b_den  = is_den(b_s);

  // flush to zero under daz, sign kept
  assign a_mag = (fpcsr.daz && a_den) ? '0 : a_s[SNG_W-2:0];
  assign b_mag = (fpcsr.daz && b_den) ? '0 : b_s[SNG_W-2:0];

  assign signal_cmp = (cmp_op_e'(stage.op) == cmp_signal);

  always_comb begin
    lt    = 1'b0;
    eq    = 1'b0;
    gt    = 1'b0;
    unord = 1'b0;
    if (a_nan || b_nan) begin
      unord = 1'b1;
    end else if (a_mag == '0 && b_mag == '0) begin
      // +0 and -0 compare equal
      eq = 1'b1;
    end else if (a_s[SNG_W-1] != b_s[SNG_W-1]) begin
      lt = a_s[SNG_W-1];
      gt = b_s[SNG_W-1];
    end else if (a_mag == b_mag) begin
      eq = 1'b1;
    end else if ((a_mag < b_mag) ^ a_s[SNG_W-1]) begin
      // magnitude order flips for negatives
      lt = 1'b1;
    end else begin
      gt = 1'b1;
    end
  end

  assign flags_d.invalid = a_snan | b_snan | (signal_cmp & (a_nan | b_nan));
  assign flags_d.denorm  = (a_den | b_den) & ~fpcsr.daz;

  always_ff @(posedge clk) begin
    res.tag   <= stage.tag;
    res.data  <= {{(DATA_W-4){1'b0}}, unord, gt, eq, lt};
    res.flags <= flags_d;
    if (rst) begin
      res.valid <= 1'b0;
      res.excpt <= 1'b0;
    end else begin
      res.valid <= stage.valid;
      res.excpt <= stage.valid & (|(flags_d & fpcsr.trap_en));
    end
  end

endmodule

// File: src/logic_perm_unit.sv
// lane 0 bitwise logic and single-precision permutes on 64-bit words
// result registered, visible two cycles after issue
module logic_perm_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  fpu_pkg::stage_t       stage,
  output fpu_pkg::perm_result_t res
);
  import fpu_pkg::*;

  perm_op_e          op;
  logic [SNG_W-1:0]  a_lo;
  logic [SNG_W-1:0]  a_hi;
  logic [SNG_W-1:0]  b_lo;
  logic [SNG_W-1:0]  b_hi;
  logic [DATA_W-1:0] data_d;

  assign op   = perm_op_e'(stage.op);
  assign a_lo = stage.a[SNG_W-1:0];
  assign a_hi = stage.a[DATA_W-1:SNG_W];
  assign b_lo = stage.b[SNG_W-1:0];
  assign b_hi = stage.b[DATA_W-1:SNG_W];

  always_comb begin
    case (op)
      op_and:    data_d = stage.a & stage.b;
      op_or:     data_d = stage.a | stage.b;
      op_xor:    data_d = stage.a ^ stage.b;
      op_andn:   data_d = stage.a & ~stage.b;
      // exchange B's halves
      op_swap:   data_d = {b_lo, b_hi};
      op_dup:    data_d = {b_lo, b_lo};
      // replace one half of B or A
      op_ins_lo: data_d = {b_hi, a_lo};
      op_ins_hi: data_d = {a_hi, b_lo};
      default:   data_d = stage.a;
    endcase
  end

  always_ff @(posedge clk) begin
    res.tag  <= stage.tag;
    res.data <= data_d;
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= stage.valid;
    end
  end

endmodule

// File: src/issue_decode.sv
// issue register into stage 1, one cycle after the issue
// lane 1 opcodes other than cmp_signal are normalized to cmp_quiet
module issue_decode (
  input  logic                       clk,
  input  logic                       rst,
  input  fpu_pkg::issue_t            issue0,
  input  fpu_pkg::issue_t            issue1,
  input  logic [fpu_pkg::DATA_W-1:0] a0,
  input  logic [fpu_pkg::DATA_W-1:0] b0,
  input  logic [fpu_pkg::DATA_W-1:0] a1,
  input  logic [fpu_pkg::DATA_W-1:0] b1,
  output fpu_pkg::stage_t            stage0,
  output fpu_pkg::stage_t            stage1
);
  import fpu_pkg::*;

  perm_op_e perm_op;
  cmp_op_e  cmp_op;

  // lane 0 uses every code as is
  assign perm_op = perm_op_e'(issue0.op);

  always_comb begin
    if (cmp_op_e'(issue1.op) == cmp_signal) begin
      cmp_op = cmp_signal;
    end else begin
      cmp_op = cmp_quiet;
    end
  end

  // lane 0 stage
  always_ff @(posedge clk) begin
    stage0.tag <= issue0.tag;
    stage0.op  <= perm_op;
    stage0.a   <= a0;
    stage0.b   <= b0;
    if (rst) begin
      stage0.valid <= 1'b0;
    end else begin
      stage0.valid <= issue0.valid;
    end
  end

  // lane 1 stage
  always_ff @(posedge clk) begin
    stage1.tag <= issue1.tag;
    stage1.op  <= cmp_op;
    stage1.a   <= a1;
    stage1.b   <= b1;
    if (rst) begin
      stage1.valid <= 1'b0;
    end else begin
      stage1.valid <= issue1.valid;
    end
  end

endmodule

// File: src/fwd_network.sv
// forwarding for both lanes' two operands
// the previous-cycle bus copy updates every cycle and has no reset
module fwd_network (
  input  logic                       clk,
  input  fpu_pkg::issue_t            issue0,
  input  fpu_pkg::issue_t            issue1,
  input  fpu_pkg::bus_array_t        buses,
  output logic [fpu_pkg::DATA_W-1:0] a0,
  output logic [fpu_pkg::DATA_W-1:0] b0,
  output logic [fpu_pkg::DATA_W-1:0] a1,
  output logic [fpu_pkg::DATA_W-1:0] b1
);
  import fpu_pkg::*;

  bus_array_t bus_prev;

  always_ff @(posedge clk) begin
    bus_prev <= buses;
  end

  // lane 0 operands
  operand_forward u_fwd_a0 (
    .reg_val  (issue0.a_reg),
    .sel      (issue0.a_sel),
    .bus_now  (buses),
    .bus_prev (bus_prev),
    .operand  (a0)
  );

  operand_forward u_fwd_b0 (
    .reg_val  (issue0.b_reg),
    .sel      (issue0.b_sel),
    .bus_now  (buses),
    .bus_prev (bus_prev),
    .operand  (b0)
  );

  // lane 1 operands
  operand_forward u_fwd_a1 (
    .reg_val  (issue1.a_reg),
    .sel      (issue1.a_sel),
    .bus_now  (buses),
    .bus_prev (bus_prev),
    .operand  (a1)
  );

  operand_forward u_fwd_b1 (
    .reg_val  (issue1.b_reg),
    .sel      (issue1.b_sel),
    .bus_now  (buses),
    .bus_prev (bus_prev),
    .operand  (b1)
  );

endmodule

// File: src/operand_forward.sv
// operand source mux, purely combinational
// an unused source code falls back to the register value
module operand_forward (
  input  logic [fpu_pkg::DATA_W-1:0] reg_val,
  input  fpu_pkg::fwd_sel_t          sel,
  input  fpu_pkg::bus_array_t        bus_now,
  input  fpu_pkg::bus_array_t        bus_prev,
  output logic [fpu_pkg::DATA_W-1:0] operand
);
  import fpu_pkg::*;

  always_comb begin
    case (sel.src)
      // result bus as it is this cycle
      src_now: begin
        operand = bus_now[sel.idx];
      end
      // same bus, one cycle back
      src_prev: begin
        operand = bus_prev[sel.idx];
      end
      default: begin
        operand = reg_val;
      end
    endcase
  end

endmodule

// File: src/fpu_pkg.sv
// shared widths, opcodes and bundles for the two-lane FP execution unit
// bus 0 is lane 0's result, bus 1 is lane 1's result, buses 2 and 3 are external
package fpu_pkg;

  localparam int DATA_W    = 64;
  localparam int SNG_W     = 32;
  localparam int EXP_W     = 8;
  localparam int MAN_W     = 23;
  localparam int NUM_BUS   = 4;
  localparam int BUS_IDX_W = $clog2(NUM_BUS);
  localparam int TAG_W     = 6;
  localparam int OP_W      = 3;

  // lane 0 logic and permute opcodes
  typedef enum logic [OP_W-1:0] {
    op_and    = 3'd0,
    op_or     = 3'd1,
    op_xor    = 3'd2,
    op_andn   = 3'd3,
    op_swap   = 3'd4,
    op_dup    = 3'd5,
    op_ins_lo = 3'd6,
    op_ins_hi = 3'd7
  } perm_op_e;

  // lane 1 compare kinds, any other code compares quietly
  typedef enum logic [OP_W-1:0] {
    cmp_quiet  = 3'd0,
    cmp_signal = 3'd1
  } cmp_op_e;

  typedef enum logic [1:0] {
    src_reg  = 2'd0,
    src_now  = 2'd1,
    src_prev = 2'd2
  } fwd_src_e;

  typedef struct packed {
    fwd_src_e               src;
    logic [BUS_IDX_W-1:0]   idx;
  } fwd_sel_t;

  typedef struct packed {
    logic invalid;
    logic denorm;
  } fp_flags_t;

  typedef struct packed {
    fp_flags_t trap_en;
    logic      daz;
  } fpcsr_t;

  typedef logic [NUM_BUS-1:0][DATA_W-1:0] bus_array_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] a_reg;
    logic [DATA_W-1:0] b_reg;
    fwd_sel_t          a_sel;
    fwd_sel_t          b_sel;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } stage_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } perm_result_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
    fp_flags_t         flags;
    logic              excpt;
  } cmp_result_t;

endpackage
